// File: include/vdp_bus_tasks.svh
`ifndef VDP_BUS_TASKS_SVH
`define VDP_BUS_TASKS_SVH

// ------------------------------
// result check
// ------------------------------
task automatic check(input string name, input logic [31:0] got,
                     input logic [31:0] expected);
  if (got !== expected) begin
    $display("Error at %0t: %s got %h expected %h", $time, name, got, expected);
    $display("TB FAILED");
    $fatal(1, "check %s failed", name);
  end
endtask

// ------------------------------
// bus cycles
// ------------------------------
task automatic io_write(input logic [1:0] m, input logic [7:0] data);
  a      <= vdp_io_base;
  mode   <= m;
  cd_in  <= data;
  iorq_n <= 1'b0;
  wr_n   <= 1'b0;
  repeat (4) @(posedge clk);
  iorq_n <= 1'b1;
  wr_n   <= 1'b1;
  repeat (4) @(posedge clk);   // recovery
endtask

task automatic io_read(input logic [1:0] m, output logic [7:0] data);
  logic oe_seen;
  oe_seen = 1'b0;
  data    = 8'hxx;
  a       <= vdp_io_base;
  mode    <= m;
  iorq_n  <= 1'b0;
  rd_n    <= 1'b0;
  repeat (6) begin
    @(posedge clk);
    if (cd_oe) begin
      oe_seen = 1'b1;
      data    = cd_out;   // last sample before rd_n rises
    end
  end
  check("cd_oe during read", {31'b0, oe_seen}, 32'd1);
  iorq_n <= 1'b1;
  rd_n   <= 1'b1;
  repeat (4) @(posedge clk);
endtask

task automatic set_addr(input logic [13:0] addr, input logic write_mode);
  io_write(port_ctrl, addr[7:0]);
  io_write(port_ctrl, {1'b0, write_mode, addr[13:8]});
endtask

// polls status until busy drops
task automatic wait_idle();
  logic [7:0] st;
  int         polls;
  st    = 8'hff;
  polls = 0;
  while (st[6]) begin
    if (polls == 100) begin
      $display("Error at %0t: status stayed busy after %0d polls", $time, polls);
      $display("TB FAILED");
      $fatal(1, "wait_idle timed out");
    end
    io_read(port_ctrl, st);
    polls = polls + 1;
  end
endtask

`endif

// File: dv/tb_vdp_bridge.sv
`timescale 1ns/1ps

module tb_vdp_bridge
  import vdp_bridge_pkg::*;
();

  logic       clk;
  logic       reset_n;
  logic [7:2] a;
  logic [1:0] mode;
  logic       iorq_n;
  logic       rd_n;
  logic       wr_n;
  logic [7:0] cd_in;
  logic [7:0] cd_out;
  logic       cd_oe;
  logic       cs_n;

  integer     seed;
  logic [7:0] ref_mem [2**vram_aw];   // updated only by our own writes

  vdp_bridge_top uut (
    .clk     (clk),
    .reset_n (reset_n),
    .a       (a),
    .mode    (mode),
    .iorq_n  (iorq_n),
    .rd_n    (rd_n),
    .wr_n    (wr_n),
    .cd_in   (cd_in),
    .cd_out  (cd_out),
    .cd_oe   (cd_oe),
    .cs_n    (cs_n)
  );

  always #4 clk = ~clk;   // 8 ns period

  `include "vdp_bus_tasks.svh"

  // ------------------------------
  // helpers
  // ------------------------------
  task automatic write_byte_at(input logic [vram_aw-1:0] addr, input logic [7:0] data);
    set_addr(addr, 1'b1);
    io_write(port_data, data);
    ref_mem[addr] = data;
  endtask

  task automatic read_byte_at(input logic [vram_aw-1:0] addr, output logic [7:0] data);
    set_addr(addr, 1'b0);
    wait_idle();   // prefetch has reached the read-ahead latch
    io_read(port_data, data);
  endtask

  // 4 cycle data write at twice the cpu slot drain rate
  task automatic burst_write(input logic [7:0] data);
    a      <= vdp_io_base;
    mode   <= port_data;
    cd_in  <= data;
    iorq_n <= 1'b0;
    wr_n   <= 1'b0;
    repeat (2) @(posedge clk);
    iorq_n <= 1'b1;
    wr_n   <= 1'b1;
    repeat (2) @(posedge clk);
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------
  task automatic probe_reset_state();
    logic [7:0] st;
    check("cs_n idle", cs_n, 1);
    check("cd_oe idle", cd_oe, 0);
    io_read(port_ctrl, st);
    check("status after reset", st, 8'h00);
    a      <= vdp_io_base;
    iorq_n <= 1'b0;        // decode only with no rd or wr
    @(posedge clk);
    check("cs_n decoded", cs_n, 0);
    a <= 6'b000110;
    @(posedge clk);
    check("cs_n outside group", cs_n, 1);
    a      <= vdp_io_base;
    iorq_n <= 1'b1;
    @(posedge clk);
  endtask

  task automatic stream_block();
    logic [vram_aw-1:0] start;
    logic [7:0]         data;
    logic [7:0]         got;
    start = 14'h0100;
    set_addr(start, 1'b1);
    for (int i = 0; i < 16; i++) begin
      data = 8'h5a ^ 8'(i * 37);
      io_write(port_data, data);
      ref_mem[vram_aw'(start + i)] = data;
    end
    wait_idle();
    set_addr(start, 1'b0);
    wait_idle();
    for (int i = 0; i < 16; i++) begin
      io_read(port_data, got);
      check($sformatf("block byte %0d", i), got, ref_mem[vram_aw'(start + i)]);
    end
  endtask

  task automatic scatter_random_bytes();
    logic [vram_aw-1:0] addrs [20];
    logic [7:0]         data;
    logic [7:0]         got;
    for (int i = 0; i < 20; i++) begin
      addrs[i] = vram_aw'($random(seed));
      data     = 8'($random(seed));
      write_byte_at(addrs[i], data);
      wait_idle();
    end
    for (int i = 0; i < 20; i++) begin
      read_byte_at(addrs[i], got);
      check($sformatf("random byte at %h", addrs[i]), got, ref_mem[addrs[i]]);
    end
  endtask

  task automatic provoke_overrun();
    logic [vram_aw-1:0] start;
    logic [7:0]         st;
    logic [7:0]         got;
    start = 14'h3000;
    set_addr(start, 1'b1);
    for (int i = 0; i < 40; i++)
      burst_write(8'hc0 + 8'(i));
    ref_mem[start] = 8'hc0;   // later bytes may have been dropped
    io_read(port_ctrl, st);
    check("overrun flag", st[7], 1);
    wait_idle();
    io_read(port_ctrl, st);
    check("status after clear", st, 8'h00);
    read_byte_at(start, got);
    check("first burst byte", got, ref_mem[start]);
  endtask

  task automatic recover_flipflop();
    logic [7:0] st;
    logic [7:0] got;
    io_write(port_ctrl, 8'h77);   // lone first byte
    io_read(port_ctrl, st);
    check("status after lone byte", st, 8'h00);
    write_byte_at(14'h0a55, 8'h3c);
    wait_idle();
    read_byte_at(14'h0a55, got);
    check("byte after recovery", got, ref_mem[14'h0a55]);
  endtask

  task automatic ignore_bad_ports();
    logic [vram_aw-1:0] base;
    logic [7:0]         got;
    base = 14'h1234;
    write_byte_at(base, 8'h81);   // address now at base + 1
    io_write(2'd2, 8'hee);
    io_write(2'd3, 8'hdd);
    io_write(port_ctrl, 8'h10);
    io_write(port_ctrl, 8'h87);   // register write with bit 7 set
    io_write(port_data, 8'h42);
    ref_mem[base + 1'b1] = 8'h42;
    wait_idle();
    read_byte_at(base, got);
    check("known byte untouched", got, ref_mem[base]);
    read_byte_at(base + 1'b1, got);
    check("address kept", got, ref_mem[base + 1'b1]);
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    seed    = 32'hc008;
    clk     = 1'b0;
    reset_n = 1'b0;
    a       = '0;
    mode    = '0;
    iorq_n  = 1'b1;
    rd_n    = 1'b1;
    wr_n    = 1'b1;
    cd_in   = 8'h00;
    repeat (10) @(posedge clk);
    reset_n <= 1'b1;
    @(posedge clk);

    probe_reset_state();
    stream_block();
    scatter_random_bytes();
    provoke_overrun();
    recover_flipflop();
    ignore_bad_ports();

    $display("TB PASSED");
    $finish;
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f vdp_bridge.f \
  --top-module tb_vdp_bridge -o sim_vdp_bridge &&
./obj_dir/sim_vdp_bridge | grep "TB PASSED" &&
echo "simulation ok" ||
{ echo "simulation did not pass"; exit 1; }

// File: source/vdp_bridge_pkg.sv
package vdp_bridge_pkg;

  // ------------------------------
  // sizes and decode constants
  // ------------------------------
  localparam int vram_aw = 14;                      // 16 KB of VRAM
  localparam logic [5:0] vdp_io_base = 6'b100110;   // ports 98h to 9Bh
  localparam int fifo_depth = 8;
  localparam int fifo_pw = $clog2(fifo_depth);      // queue pointer width
  localparam int fifo_lw = $clog2(fifo_depth + 1);  // fill level width
  localparam int slot_cycles = 8;                   // one cpu slot per wheel

  // ------------------------------
  // enums
  // ------------------------------
  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } vram_op_e;

  // follows the mode pins
  typedef enum logic [1:0] {
    port_data = 2'd0,
    port_ctrl = 2'd1
  } port_sel_e;

  typedef enum logic [2:0] {
    ph_refresh,
    ph_fetch0,
    ph_fetch1,
    ph_fetch2,
    ph_fetch3,
    ph_fetch4,
    ph_fetch5,
    ph_cpu
  } slot_phase_e;

  typedef struct packed {
    vram_op_e           op;
    logic [vram_aw-1:0] addr;
    logic [7:0]         wdata;   // don't care for reads
  } vram_req_t;

endpackage

// File: source/vdp_bridge_top.sv
`timescale 1ns/1ps

module vdp_bridge_top (
  input  logic       clk,
  input  logic       reset_n,

  // z80 side io bus
  input  logic [7:2] a,
  input  logic [1:0] mode,
  input  logic       iorq_n,
  input  logic       rd_n,
  input  logic       wr_n,

  // split data bus
  input  logic [7:0] cd_in,
  output logic [7:0] cd_out,
  output logic       cd_oe,
  output logic       cs_n
);

  logic       rd_strobe;
  logic [7:0] rd_data;

  // ------------------------------
  // request path
  // ------------------------------
  vram_req_if q_in_if ();    // port to queue
  vram_req_if q_out_if ();   // queue to sequencer

  vdp_cpu_port u_cpu_port (
    .clk       (clk),
    .reset_n   (reset_n),
    .a         (a),
    .mode      (mode),
    .iorq_n    (iorq_n),
    .rd_n      (rd_n),
    .wr_n      (wr_n),
    .cd_in     (cd_in),
    .cd_out    (cd_out),
    .cd_oe     (cd_oe),
    .cs_n      (cs_n),
    .req       (q_in_if.producer),
    .rd_strobe (rd_strobe),
    .rd_data   (rd_data)
  );

  vram_req_fifo u_req_fifo (
    .clk     (clk),
    .reset_n (reset_n),
    .wr      (q_in_if.writer),
    .rd      (q_out_if.reader)
  );

  vram_sequencer u_sequencer (
    .clk       (clk),
    .reset_n   (reset_n),
    .req       (q_out_if.consumer),
    .rd_strobe (rd_strobe),   // read return back to the port
    .rd_data   (rd_data)
  );

endmodule

// File: source/vdp_cpu_port.sv
`timescale 1ns/1ps

module vdp_cpu_port
  import vdp_bridge_pkg::*;
(
  input  logic         clk,
  input  logic         reset_n,
  input  logic [7:2]   a,
  input  logic [1:0]   mode,
  input  logic         iorq_n,
  input  logic         rd_n,
  input  logic         wr_n,
  input  logic [7:0]   cd_in,
  output logic [7:0]   cd_out,
  output logic         cd_oe,
  output logic         cs_n,
  vram_req_if.producer req,
  input  logic         rd_strobe,
  input  logic [7:0]   rd_data
);

  // ------------------------------
  // strobe sync and decode
  // ------------------------------
  logic [1:0] iorq_sync;
  logic [1:0] rd_sync;
  logic [1:0] wr_sync;
  logic       a_hit;
  logic       is_data;
  logic       is_ctrl;
  logic       port_ok;
  logic       wr_act;
  logic       rd_act;
  logic       wr_act_q;
  logic       rd_act_q;
  logic       wr_accept;
  logic       rd_accept;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      iorq_sync <= 2'b11;   // idle bus is high
      rd_sync   <= 2'b11;
      wr_sync   <= 2'b11;
      wr_act_q  <= 1'b0;
      rd_act_q  <= 1'b0;
    end else begin
      iorq_sync <= {iorq_sync[0], iorq_n};
      rd_sync   <= {rd_sync[0], rd_n};
      wr_sync   <= {wr_sync[0], wr_n};
      wr_act_q  <= wr_act;
      rd_act_q  <= rd_act;
    end
  end

  assign a_hit   = (a == vdp_io_base);
  assign cs_n    = iorq_n | ~a_hit;     // straight from the pins
  assign is_data = (mode == port_data);
  assign is_ctrl = (mode == port_ctrl);
  assign port_ok = a_hit & (is_data | is_ctrl);   // modes 2 and 3 fall out here

  assign wr_act    = ~iorq_sync[1] & ~wr_sync[1] & port_ok;
  assign rd_act    = ~iorq_sync[1] & ~rd_sync[1] & port_ok;
  assign wr_accept = wr_act & ~wr_act_q;
  assign rd_accept = rd_act & ~rd_act_q;

  // ------------------------------
  // request generation
  // ------------------------------
  logic [vram_aw-1:0] vaddr;
  logic [vram_aw-1:0] new_addr;
  logic [7:0]         addr_lo;
  logic               second_byte;
  logic               ctrl_addr;
  logic               want_push;
  logic               rd_issue;
  vram_req_t          push_req;

  assign new_addr  = {cd_in[5:0], addr_lo};
  // second control byte with bit 7 clear sets the address
  assign ctrl_addr = wr_accept & is_ctrl & second_byte & ~cd_in[7];

  always_comb begin
    want_push      = 1'b0;
    push_req.op    = op_read;
    push_req.addr  = vaddr;
    push_req.wdata = 8'h00;
    if (wr_accept && is_data) begin
      want_push      = 1'b1;
      push_req.op    = op_write;
      push_req.wdata = cd_in;
    end else if (rd_accept && is_data) begin
      want_push = 1'b1;           // read-ahead of the next byte
    end else if (ctrl_addr && !cd_in[6]) begin
      want_push     = 1'b1;       // read setup prefetch
      push_req.addr = new_addr;
    end
  end

  assign req.req_push = want_push & ~req.full;
  assign req.req_in   = push_req;
  assign rd_issue     = req.req_push & (push_req.op == op_read);

  // ------------------------------
  // address, status and latches
  // ------------------------------
  logic               overrun;
  logic               busy;
  logic [fifo_lw-1:0] rd_outstanding;
  logic [7:0]         rd_ahead;
  logic [7:0]         status;
  logic [7:0]         sel_byte;
  logic [7:0]         cd_hold;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      vaddr          <= '0;
      second_byte    <= 1'b0;
      overrun        <= 1'b0;
      rd_outstanding <= '0;
      cd_hold        <= 8'h00;
    end else begin
      if (want_push && req.full)
        overrun <= 1'b1;            // request dropped
      else if (rd_accept && is_ctrl)
        overrun <= 1'b0;

      if (rd_accept && is_ctrl)
        second_byte <= 1'b0;
      else if (wr_accept && is_ctrl)
        second_byte <= ~second_byte;

      if ((wr_accept || rd_accept) && is_data)
        vaddr <= vaddr + 1'b1;      // post-increment
      else if (ctrl_addr)
        vaddr <= cd_in[6] ? new_addr : new_addr + 1'b1;

      if (rd_issue && !rd_strobe)
        rd_outstanding <= rd_outstanding + 1'b1;
      else if (!rd_issue && rd_strobe)
        rd_outstanding <= rd_outstanding - 1'b1;

      if (rd_accept)
        cd_hold <= sel_byte;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_accept && is_ctrl && !second_byte)
      addr_lo <= cd_in;
    if (rd_strobe)
      rd_ahead <= rd_data;
  end

  assign busy     = ~req.empty | (rd_outstanding != '0);
  assign status   = {overrun, busy, 6'b000000};
  assign sel_byte = is_data ? rd_ahead : status;
  assign cd_out   = rd_accept ? sel_byte : cd_hold;   // stable for the whole read
  assign cd_oe    = rd_act;

  // every returned byte must answer a queued read
  a_rd_expected: assert property (@(posedge clk) disable iff (!reset_n)
    rd_strobe |-> rd_outstanding != '0);

endmodule

// File: source/vram_req_fifo.sv
`timescale 1ns/1ps

module vram_req_fifo
  import vdp_bridge_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  vram_req_if.writer wr,
  vram_req_if.reader rd
);

  vram_req_t          mem [fifo_depth];
  logic [fifo_pw-1:0] wr_ptr;
  logic [fifo_pw-1:0] rd_ptr;
  logic [fifo_lw-1:0] count;
  logic               do_push;
  logic               do_pop;

  assign do_push = wr.req_push & ~wr.full;
  assign do_pop  = rd.req_pop & ~rd.empty;

  // ------------------------------
  // pointers and count
  // ------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;   // wraps by itself at a power of two depth
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (do_push)
      mem[wr_ptr] <= wr.req_in;
  end

  assign wr.full    = (count == fifo_lw'(fifo_depth));
  assign wr.empty   = (count == '0);
  assign wr.level   = count;
  assign rd.empty   = (count == '0);
  assign rd.level   = count;
  assign rd.req_out = mem[rd_ptr];

  a_level_max: assert property (@(posedge clk) disable iff (!reset_n)
    rd.level <= fifo_lw'(fifo_depth));

endmodule

// File: source/vram_req_if.sv
`timescale 1ns/1ps

interface vram_req_if
  import vdp_bridge_pkg::*;
();

  // write side
  logic               req_push;
  vram_req_t          req_in;
  logic               full;

  // read side
  logic               req_pop;
  vram_req_t          req_out;   // head entry, always valid when not empty

  logic               empty;
  logic [fifo_lw-1:0] level;

  modport producer (output req_push, output req_in, input full, input empty);

  modport writer (input req_push, input req_in, output full, output empty,
                  output level);

  modport consumer (output req_pop, input req_out, input empty);

  modport reader (input req_pop, output req_out, output empty, output level);

endinterface

// File: source/vram_sequencer.sv
`timescale 1ns/1ps

module vram_sequencer
  import vdp_bridge_pkg::*;
(
  input  logic         clk,
  input  logic         reset_n,
  vram_req_if.consumer req,
  output logic         rd_strobe,
  output logic [7:0]   rd_data
);

  logic [7:0]  vram [2**vram_aw];
  slot_phase_e phase;
  logic        cpu_slot;
  vram_req_t   head;

  // ------------------------------
  // slot wheel
  // ------------------------------
  // refresh and fetch slots belong to the unmodelled display side
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n)
      phase <= ph_refresh;
    else if (phase == slot_phase_e'(slot_cycles - 1))
      phase <= ph_refresh;
    else
      phase <= slot_phase_e'(phase + 1'b1);
  end

  assign cpu_slot    = (phase == ph_cpu);
  assign req.req_pop = cpu_slot & ~req.empty;   // at most one pop per wheel
  assign head        = req.req_out;

  // ------------------------------
  // VRAM access
  // ------------------------------
  always_ff @(posedge clk) begin
    if (req.req_pop && head.op == op_write)
      vram[head.addr] <= head.wdata;
    if (req.req_pop && head.op == op_read)
      rd_data <= vram[head.addr];   // registered return
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n)
      rd_strobe <= 1'b0;
    else
      rd_strobe <= req.req_pop & (head.op == op_read);
  end

  // cpu pops only in its own slot and never from an empty queue
  a_pop_slot: assert property (@(posedge clk) disable iff (!reset_n)
    req.req_pop |-> cpu_slot && !req.empty);

endmodule

// File: vdp_bridge.f
+incdir+include
source/vdp_bridge_pkg.sv
source/vram_req_if.sv
source/vdp_cpu_port.sv
source/vram_req_fifo.sv
source/vram_sequencer.sv
source/vdp_bridge_top.sv
dv/tb_vdp_bridge.sv
